//--- common/gamePkg.sv
package gamePkg;

	// coordinate and fixed point widths
	localparam int COORD_W = 11;                    // holds 0..2047, enough for 640 plus a sprite
	localparam int FRAC_BITS = 6;                   // one pixel is 64 units
	localparam int POS_W = COORD_W + FRAC_BITS;     // fixed point position width

	// screen size in pixels
	localparam logic [COORD_W-1:0] SCREEN_WIDTH = 11'd640;
	localparam logic [COORD_W-1:0] SCREEN_HEIGHT = 11'd480;

	// sprites are squares
	localparam logic [COORD_W-1:0] PLAYER_SIZE = 11'd32;
	localparam logic [COORD_W-1:0] OBSTACLE_SIZE = 11'd32;

	// player placement
	localparam logic [COORD_W-1:0] PLAYER_Y = 11'd415;   // fixed row near the bottom
	localparam logic [COORD_W-1:0] INITIAL_X = 11'd304;  // roughly centred

	// player motion in fixed point units
	localparam logic [POS_W-1:0] PLAYER_STEP = 17'd150;  // about 2.34 pixels per frame
	localparam logic [POS_W-1:0] PLAYER_X_MAX =
		{SCREEN_WIDTH - PLAYER_SIZE, {FRAC_BITS{1'b0}}}; // 608 pixels shifted up
	localparam logic [POS_W-1:0] PLAYER_X_INIT =
		{INITIAL_X, {FRAC_BITS{1'b0}}};

	// obstacle fall in whole pixels
	localparam logic [COORD_W-1:0] FALL_SPEED = 11'd8;   // 60 frames top to bottom

	// 10 bit fibonacci lfsr for the column choice
	localparam int LFSR_W = 10;
	localparam logic [LFSR_W-1:0] LFSR_SEED = 10'h2a5;   // any nonzero value works
	localparam logic [LFSR_W-1:0] LFSR_TAPS = 10'h240;   // bits 9 and 6

	// game rules
	localparam logic [1:0] START_LIVES = 2'd3;
	localparam int SHIELD_W = 5;
	localparam logic [SHIELD_W-1:0] SHIELD_FRAMES = 5'd30; // one second at 30Hz

	// controller states
	typedef enum logic [1:0] {
		PLAYING = 2'd0,   // normal play, hits cost a life
		SHIELDED = 2'd1,  // hits ignored until timer runs out
		OVER = 2'd2       // no lives left
	} gameState;

endpackage

//--- hdl/playerLogic.sv
`timescale 1ns/1ps

module playerLogic (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,  // one cycle pulse per frame
	input logic left,          // button level
	input logic right,         // button level
	input logic active,        // low once the game is over
	output logic [gamePkg::COORD_W-1:0] playerX  // left edge in pixels
);

	// x position kept with FRAC_BITS of fraction
	logic [gamePkg::POS_W-1:0] posFix;
	logic moveRight;
	logic moveLeft;
	logic atRightEdge;
	logic atLeftEdge;

	// exactly one button, so both or none means stand still
	assign moveRight = right && !left;
	assign moveLeft = left && !right;

	// a full step would cross the limit
	assign atRightEdge = posFix >= (gamePkg::PLAYER_X_MAX - gamePkg::PLAYER_STEP);
	assign atLeftEdge = posFix < gamePkg::PLAYER_STEP;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			posFix <= gamePkg::PLAYER_X_INIT;
		end else if (startOfFrame && active) begin
			if (moveRight) begin
				if (atRightEdge)
					posFix <= gamePkg::PLAYER_X_MAX;  // clamp against the right border
				else
					posFix <= posFix + gamePkg::PLAYER_STEP;
			end else if (moveLeft) begin
				if (atLeftEdge)
					posFix <= '0;                     // clamp at column 0
				else
					posFix <= posFix - gamePkg::PLAYER_STEP;
			end
		end
	end

	// drop the fraction to get whole pixels
	assign playerX = posFix[gamePkg::POS_W-1:gamePkg::FRAC_BITS];

	// sprite must stay fully on screen
	posInRange: assert property (
		@(posedge clk) disable iff (!resetN)
		posFix <= gamePkg::PLAYER_X_MAX
	) else $error("player position past right limit");

endmodule

//--- obstacle/obstacleLogic.sv
`timescale 1ns/1ps

module obstacleLogic (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,  // one cycle pulse per frame
	input logic active,        // freeze when the game is over
	output logic [gamePkg::COORD_W-1:0] obstacleX,
	output logic [gamePkg::COORD_W-1:0] obstacleY,
	output logic passed        // obstacle left the bottom, one cycle
);

	logic [gamePkg::LFSR_W-1:0] lfsr;
	logic [gamePkg::LFSR_W-1:0] lfsrNext;
	logic feedback;
	logic [gamePkg::COORD_W-1:0] yNext;
	logic wrap;

	// xor of the tapped bits shifts in at the bottom
	assign feedback = ^(lfsr & gamePkg::LFSR_TAPS);
	assign lfsrNext = {lfsr[gamePkg::LFSR_W-2:0], feedback};

	// next row and whether it runs off the screen
	assign yNext = obstacleY + gamePkg::FALL_SPEED;
	assign wrap = yNext >= gamePkg::SCREEN_HEIGHT;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lfsr <= gamePkg::LFSR_SEED;
			obstacleX <= gamePkg::COORD_W'(gamePkg::LFSR_SEED[8:0]);  // first column from seed
			obstacleY <= '0;
		end else if (startOfFrame && active) begin
			if (wrap) begin
				lfsr <= lfsrNext;                            // one step per wrap
				obstacleX <= gamePkg::COORD_W'(lfsrNext[8:0]);  // below 512 so it fits
				obstacleY <= '0;                             // back to the top
			end else begin
				obstacleY <= yNext;
			end
		end
	end

	// pulse only in the cycle right after a wrapping tick
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			passed <= 1'b0;
		else
			passed <= startOfFrame && active && wrap;
	end

	// an all zero lfsr would lock up forever
	lfsrNonZero: assert property (
		@(posedge clk) disable iff (!resetN)
		lfsr != '0
	) else $error("obstacle lfsr reached zero");

endmodule

//--- hdl/collisionDetect.sv
`timescale 1ns/1ps

module collisionDetect (
	input logic [gamePkg::COORD_W-1:0] playerX,
	input logic [gamePkg::COORD_W-1:0] playerY,
	input logic [gamePkg::COORD_W-1:0] obstacleX,
	input logic [gamePkg::COORD_W-1:0] obstacleY,
	output logic overlap  // squares share a pixel
);

	// one past the right and bottom edges of each square
	logic [gamePkg::COORD_W-1:0] playerRight;
	logic [gamePkg::COORD_W-1:0] playerBottom;
	logic [gamePkg::COORD_W-1:0] obstacleRight;
	logic [gamePkg::COORD_W-1:0] obstacleBottom;
	logic overlapX;
	logic overlapY;

	assign playerRight = playerX + gamePkg::PLAYER_SIZE;       // max 671, no overflow
	assign playerBottom = playerY + gamePkg::PLAYER_SIZE;
	assign obstacleRight = obstacleX + gamePkg::OBSTACLE_SIZE;
	assign obstacleBottom = obstacleY + gamePkg::OBSTACLE_SIZE;

	// half open intervals overlap when each starts before the other ends
	assign overlapX = (playerX < obstacleRight) && (obstacleX < playerRight);
	assign overlapY = (playerY < obstacleBottom) && (obstacleY < playerBottom);

	// both axes needed for a hit
	assign overlap = overlapX && overlapY;

endmodule

//--- hdl/gameControl.sv
`timescale 1ns/1ps

module gameControl (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,  // one cycle pulse per frame
	input logic overlap,       // player touches obstacle
	input logic passed,        // obstacle got past, cycle after the tick
	input logic invincible,    // request for a shield
	output logic active,       // world keeps moving
	output logic shielded,
	output logic gameOver,
	output logic [1:0] lives,
	output logic [15:0] score
);

	gamePkg::gameState state;
	logic [gamePkg::SHIELD_W-1:0] shieldTimer;  // frames of shield left
	logic [gamePkg::SHIELD_W-1:0] timerNext;

	assign timerNext = shieldTimer - 1'b1;

	// lives, shield and state all move on the frame tick
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= gamePkg::PLAYING;
			lives <= gamePkg::START_LIVES;
			shieldTimer <= '0;
		end else if (startOfFrame) begin
			case (state)
				gamePkg::PLAYING: begin
					if (overlap) begin
						lives <= lives - 1'b1;
						if (lives == 2'd1) begin
							state <= gamePkg::OVER;              // last life gone
						end else begin
							state <= gamePkg::SHIELDED;
							shieldTimer <= gamePkg::SHIELD_FRAMES;  // grace period after a hit
						end
					end else if (invincible) begin
						state <= gamePkg::SHIELDED;
						shieldTimer <= gamePkg::SHIELD_FRAMES;
					end
				end
				gamePkg::SHIELDED: begin
					// overlaps are ignored here
					if (invincible) begin
						shieldTimer <= gamePkg::SHIELD_FRAMES;  // keep shield up while requested
					end else begin
						shieldTimer <= timerNext;
						if (timerNext == '0)
							state <= gamePkg::PLAYING;         // shield ran out
					end
				end
				gamePkg::OVER: begin
					state <= gamePkg::OVER;  // only reset leaves
				end
				default: begin
					state <= gamePkg::PLAYING;
				end
			endcase
		end
	end

	// passes count in every state but OVER
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			score <= '0;
		else if (passed && state != gamePkg::OVER)
			score <= score + 1'b1;
	end

	assign active = state != gamePkg::OVER;
	assign shielded = state == gamePkg::SHIELDED;
	assign gameOver = state == gamePkg::OVER;

	// end of game only ever with no lives left
	overNoLives: assert property (
		@(posedge clk) disable iff (!resetN)
		gameOver |-> (lives == 2'd0)
	) else $error("game over with lives remaining");

endmodule

//--- hdl/gameTop.sv
`timescale 1ns/1ps

module gameTop (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,  // one cycle pulse per frame
	input logic left,
	input logic right,
	input logic invincible,
	output logic [gamePkg::COORD_W-1:0] playerX,
	output logic [gamePkg::COORD_W-1:0] playerY,
	output logic [gamePkg::COORD_W-1:0] obstacleX,
	output logic [gamePkg::COORD_W-1:0] obstacleY,
	output logic [1:0] lives,
	output logic [15:0] score,
	output logic shielded,
	output logic gameOver
);

	logic active;   // controller lets the world move
	logic passed;   // obstacle wrapped
	logic overlap;  // hit this frame

	assign playerY = gamePkg::PLAYER_Y;  // player row never changes

	playerLogic player (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.left(left),
		.right(right),
		.active(active),
		.playerX(playerX)
	);

	obstacleLogic obstacle (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.active(active),
		.obstacleX(obstacleX),
		.obstacleY(obstacleY),
		.passed(passed)
	);

	// purely combinational on the current coordinates
	collisionDetect collision (
		.playerX(playerX),
		.playerY(playerY),
		.obstacleX(obstacleX),
		.obstacleY(obstacleY),
		.overlap(overlap)
	);

	gameControl control (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.overlap(overlap),
		.passed(passed),
		.invincible(invincible),
		.active(active),
		.shielded(shielded),
		.gameOver(gameOver),
		.lives(lives),
		.score(score)
	);

endmodule

//--- dv/gameTb.sv
`timescale 1ns/1ps

module gameTb;

	localparam string DATA_FILE = "dv/gameInput.txt";
	localparam int CYCLES_PER_FRAME = 5;  // drive, tick, three cycles to settle

	logic clk = 1'b0;
	logic resetN;
	logic startOfFrame;
	logic left;
	logic right;
	logic invincible;
	logic [gamePkg::COORD_W-1:0] playerX;
	logic [gamePkg::COORD_W-1:0] playerY;
	logic [gamePkg::COORD_W-1:0] obstacleX;
	logic [gamePkg::COORD_W-1:0] obstacleY;
	logic [1:0] lives;
	logic [15:0] score;
	logic shielded;
	logic gameOver;

	// one entry per line of the data file
	int leftQ[$];
	int rightQ[$];
	int invQ[$];
	int frameQ[$];
	int expXQ[$];
	int expLivesQ[$];
	int expScoreQ[$];
	int expOverQ[$];

	int errorCount = 0;
	int totalFrames = 0;
	int watchdogCycles = 0;  // stays 0 until the frame count is known

	gameTop UUT (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.left(left),
		.right(right),
		.invincible(invincible),
		.playerX(playerX),
		.playerY(playerY),
		.obstacleX(obstacleX),
		.obstacleY(obstacleY),
		.lives(lives),
		.score(score),
		.shielded(shielded),
		.gameOver(gameOver)
	);

	always #10 clk = ~clk;  // 20 ns period

	// data lines have eight numbers, lines starting with # are notes
	task automatic loadStimulus();
		int fd;
		int n;
		int l;
		int r;
		int inv;
		int cnt;
		int x;
		int lv;
		int sc;
		int ov;
		string line;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file %s", DATA_FILE);
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%d %d %d %d %d %d %d %d", l, r, inv, cnt, x, lv, sc, ov);
			if (n == 8) begin
				leftQ.push_back(l);
				rightQ.push_back(r);
				invQ.push_back(inv);
				frameQ.push_back(cnt);
				expXQ.push_back(x);
				expLivesQ.push_back(lv);
				expScoreQ.push_back(sc);
				expOverQ.push_back(ov);
				totalFrames += cnt;
			end else if (n > 0) begin
				errorCount++;  // half a line is a broken file, not a note
				$display("malformed line in the stimulus file: %s", line);
			end
		end
		$fclose(fd);
	endtask

	// buttons change on the edge that raises the tick
	task automatic playFrame(input int l, input int r, input int inv);
		@(posedge clk);
		left <= (l != 0);
		right <= (r != 0);
		invincible <= (inv != 0);
		startOfFrame <= 1'b1;
		@(posedge clk);  // the tick edge
		startOfFrame <= 1'b0;
		repeat (3) @(posedge clk);  // score trails the wrap by two cycles
	endtask

	// 10 bit column generator, taps at bits 9 and 6 feed bit 0
	function automatic int stepColumn(input int value);
		int fb;
		fb = ((value >> 9) ^ (value >> 6)) & 1;
		return ((value << 1) | fb) & 'h3ff;
	endfunction

	// shield frames left after a tick without a hit
	function automatic int shieldAfterTick(input int framesLeft, input int inv);
		if (inv != 0)
			return int'(gamePkg::SHIELD_FRAMES);  // a request reloads the timer
		if (framesLeft > 0)
			return framesLeft - 1;
		return 0;
	endfunction

	task automatic compareValue(input string name, input int actual, input int expected);
		assert (actual == expected) else begin
			errorCount++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	// state right after reset, seed 10'h2a5 gives column 165
	task automatic checkReset();
		compareValue("playerX", int'(playerX), 304);
		compareValue("playerY", int'(playerY), 415);
		compareValue("obstacleX", int'(obstacleX), 165);
		compareValue("obstacleY", int'(obstacleY), 0);
		compareValue("lives", int'(lives), 3);
		compareValue("score", int'(score), 0);
		compareValue("shielded", int'(shielded), 0);
		compareValue("gameOver", int'(gameOver), 0);
	endtask

	task automatic checkGroup(input int idx, input int expY, input int expCol,
			input int expShield);
		compareValue("playerX", int'(playerX), expXQ[idx]);
		compareValue("lives", int'(lives), expLivesQ[idx]);
		compareValue("score", int'(score), expScoreQ[idx]);
		compareValue("gameOver", int'(gameOver), expOverQ[idx]);
		compareValue("obstacleY", int'(obstacleY), expY);
		compareValue("obstacleX", int'(obstacleX), expCol);
		compareValue("shielded", int'(shielded), expShield);
	endtask

	initial begin
		int expY;
		int overBefore;
		int column;
		int shieldLeft;
		int livesBefore;
		resetN = 1'b0;
		startOfFrame = 1'b0;
		left = 1'b0;
		right = 1'b0;
		invincible = 1'b0;
		expY = 0;
		overBefore = 0;
		column = int'(gamePkg::LFSR_SEED);  // generator starts at the seed
		shieldLeft = 0;
		livesBefore = 3;
		loadStimulus();
		if (frameQ.size() == 0) begin
			errorCount++;
			$display("no frames could be read from %s", DATA_FILE);
		end else begin
			watchdogCycles = (totalFrames + 10) * CYCLES_PER_FRAME;
			repeat (3) @(posedge clk);
			resetN <= 1'b1;
			@(negedge clk);
			checkReset();
			foreach (frameQ[i]) begin
				repeat (frameQ[i]) begin
					playFrame(leftQ[i], rightQ[i], invQ[i]);
					// falls 8 rows per tick and wraps at 480 while the game runs
					if (overBefore == 0) begin
						if (expY + int'(gamePkg::FALL_SPEED) >= 480) begin
							expY = 0;
							column = stepColumn(column);  // new column on every wrap
						end else begin
							expY = expY + int'(gamePkg::FALL_SPEED);
						end
						shieldLeft = shieldAfterTick(shieldLeft, invQ[i]);
					end
				end
				// a hit lands on the last frame of its line and starts a fresh shield
				if (expLivesQ[i] < livesBefore)
					shieldLeft = (expOverQ[i] != 0) ? 0 : int'(gamePkg::SHIELD_FRAMES);
				@(negedge clk);  // outputs settled long ago
				checkGroup(i, expY, column & 'h1ff, (shieldLeft != 0) ? 1 : 0);
				overBefore = expOverQ[i];  // game over lands on the last frame of a line
				livesBefore = expLivesQ[i];
			end
		end
		$display("errors: %0d", errorCount);
		if (errorCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// limit follows the number of frames in the data file
	initial begin
		wait (watchdogCycles > 0);
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout after %0d cycles, the frame sequence did not finish", watchdogCycles);
		$display("errors: %0d", errorCount);
		$display("Checks failed");
		$finish;
	end

endmodule

//--- dv/gameInput.txt
# left right invincible frames | expected playerX lives score gameOver
# each line plays its frames with the same buttons, outputs are checked after the last one
0 0 0 5 304 3 0 0
1 1 0 5 304 3 0 0
0 0 0 50 304 3 1 0
0 0 0 48 304 3 1 0
# obstacle at column 331 reaches the player row
0 0 0 1 304 2 1 0
0 0 0 7 304 2 1 0
0 0 0 4 304 2 2 0
1 1 0 20 304 2 2 0
0 0 0 84 304 2 3 0
# shield requested before the column 303 obstacle arrives
0 0 1 1 304 2 3 0
0 0 0 11 304 2 3 0
# sweep to the right border
0 1 0 1 306 2 3 0
0 1 0 2 311 2 3 0
0 1 0 37 397 2 4 0
0 1 0 90 608 2 6 0
0 1 0 10 608 2 6 0
# sweep to the left border
1 0 0 1 605 2 6 0
1 0 0 99 373 2 7 0
1 0 0 159 0 2 10 0
1 0 0 1 0 2 10 0
1 0 0 10 0 2 10 0
0 0 0 54 0 2 11 0
# line up with the column 43 obstacle
0 1 0 10 23 2 11 0
0 0 0 58 23 2 12 0
0 0 0 1 23 1 12 0
0 0 0 7 23 1 12 0
# line up with the column 87 obstacle for the last hit
0 1 0 25 82 1 13 0
0 0 0 27 82 1 13 0
0 0 0 1 82 0 13 1
# game over, buttons move nothing
0 1 0 10 82 0 13 1
1 0 0 10 82 0 13 1
0 0 0 60 82 0 13 1
1 1 1 5 82 0 13 1

//--- build.f
common/gamePkg.sv
hdl/playerLogic.sv
obstacle/obstacleLogic.sv
hdl/collisionDetect.sv
hdl/gameControl.sv
hdl/gameTop.sv
dv/gameTb.sv

//--- run.sh
#!/bin/sh
# build and run the game testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module gameTb -f build.f \
	--Mdir obj_dir -o gameSim > build.log 2>&1 \
	|| { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/gameSim > sim.log 2>&1 || echo "simulator exited with an error"
grep -qx "All checks passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
